/* hw/tnn_pkg.sv */
package tnn_pkg;

  // width helpers, also used by the top level for derived widths
  // signed accumulator wide enough for feat_cnt features at full scale
  function automatic int acc_width(int feat_cnt, int feat_bits);
    return $clog2(feat_cnt * ((1 << feat_bits) - 1) + 1) + 1;
  endfunction

  // signed score covering +/- hidden_cnt
  function automatic int score_width(int hidden_cnt);
    return $clog2(hidden_cnt + 1) + 1;
  endfunction

  // index into cnt entries, never narrower than one bit
  function automatic int index_width(int cnt);
    return (cnt > 1) ? $clog2(cnt) : 1;
  endfunction

  // default network dimensions
  localparam int FEAT_CNT   = 8;
  localparam int FEAT_BITS  = 4;
  localparam int HIDDEN_CNT = 8;
  localparam int CLASS_CNT  = 4;

  localparam int ACC_BITS   = acc_width(FEAT_CNT, FEAT_BITS);
  localparam int SCORE_BITS = score_width(HIDDEN_CNT);
  localparam int CLASS_BITS = index_width(CLASS_CNT);

  // first layer weights, bit h*FEAT_CNT+f belongs to neuron h, feature f
  // mask set means non-zero weight, sign set means +1
  localparam logic [HIDDEN_CNT*FEAT_CNT-1:0] L1_MASK = 64'hB56E_D37A_9CE6_5BAD;
  localparam logic [HIDDEN_CNT*FEAT_CNT-1:0] L1_SIGN = 64'h934C_A138_8B62_19C5;

  // output layer weights, bit c*HIDDEN_CNT+h belongs to class c, hidden bit h
  localparam logic [CLASS_CNT*HIDDEN_CNT-1:0] L2_MASK = 32'hEB7D_DEB7;
  localparam logic [CLASS_CNT*HIDDEN_CNT-1:0] L2_SIGN = 32'h69A5_3C96;

endpackage

/* hw/ternary_accumulator.sv */
module ternary_accumulator #(
  parameter int ACC_BITS = tnn_pkg::ACC_BITS
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start,
  input  logic signed [ACC_BITS-1:0] sample,
  input  logic                       enable,
  output logic                       positive
);

  // running sum of the current pass
  logic signed [ACC_BITS-1:0] sum;

  // start replaces the old sum, enable keeps adding
  always_ff @(posedge clk) begin
    if (start) begin
      sum <= sample;
    end else if (enable) begin
      sum <= sum + sample;
    end
  end

  // activation: strictly above zero
  assign positive = (sum > 0);

  // width from the package must keep the sum from wrapping
  // two same-sign operands must give a sum of that sign
  a_no_wrap : assert property (
    @(posedge clk) disable iff (rst)
    (enable && !start && (sum[ACC_BITS-1] == sample[ACC_BITS-1]))
    |=> (sum[ACC_BITS-1] == $past(sample[ACC_BITS-1]))
  ) else $error("accumulator wrapped");

endmodule

/* hw/ternary_first_layer.sv */
module ternary_first_layer #(
  parameter int FEAT_CNT   = tnn_pkg::FEAT_CNT,
  parameter int FEAT_BITS  = tnn_pkg::FEAT_BITS,
  parameter int HIDDEN_CNT = tnn_pkg::HIDDEN_CNT,
  parameter int ACC_BITS   = tnn_pkg::ACC_BITS,
  parameter logic [HIDDEN_CNT*FEAT_CNT-1:0] W_MASK = tnn_pkg::L1_MASK,
  parameter logic [HIDDEN_CNT*FEAT_CNT-1:0] W_SIGN = tnn_pkg::L1_SIGN
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          in_valid,
  input  logic [FEAT_CNT*FEAT_BITS-1:0] features,
  input  logic                          hid_ready,
  output logic                          in_ready,
  output logic                          hid_valid,
  output logic [HIDDEN_CNT-1:0]         hidden
);

  localparam int CNT_BITS = tnn_pkg::index_width(FEAT_CNT);
  localparam logic [CNT_BITS-1:0] CNT_LAST = CNT_BITS'(FEAT_CNT - 1);

  logic [FEAT_CNT*FEAT_BITS-1:0] feat_q;
  logic [CNT_BITS-1:0]           cnt;
  logic                          busy;
  logic                          stall;
  logic                          step;
  logic                          last;
  logic                          accept;
  logic                          acc_start;
  logic                          acc_enable;

  // result waiting downstream freezes the walk
  assign stall = hid_valid && !hid_ready;
  assign step  = busy && !stall;
  assign last  = (cnt == CNT_LAST);

  // next vector may come in on the edge of the last feature, never during reset
  assign in_ready = !rst && !stall && (!busy || last);
  assign accept   = in_valid && in_ready;

  assign acc_start  = step && (cnt == '0);
  assign acc_enable = step && (cnt != '0);

  // latched feature vector
  always_ff @(posedge clk) begin
    if (accept) begin
      feat_q <= features;
    end
  end

  // feature sequencer
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy <= 1'b0;
      cnt  <= '0;
    end else if (accept) begin
      busy <= 1'b1;
      cnt  <= '0;
    end else if (step) begin
      if (last) begin
        busy <= 1'b0;
        cnt  <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // hidden result handshake
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      hid_valid <= 1'b0;
    end else if (step && last) begin
      hid_valid <= 1'b1;
    end else if (hid_ready) begin
      hid_valid <= 1'b0;
    end
  end

  // features widened to the accumulator width, zero extended
  logic signed [ACC_BITS-1:0] feat_ext [FEAT_CNT];

  for (genvar f = 0; f < FEAT_CNT; f++) begin : g_feat
    assign feat_ext[f] = {{(ACC_BITS - FEAT_BITS){1'b0}}, feat_q[f*FEAT_BITS +: FEAT_BITS]};
  end

  for (genvar h = 0; h < HIDDEN_CNT; h++) begin : g_neuron
    localparam logic [FEAT_CNT-1:0] MASK = W_MASK[h*FEAT_CNT +: FEAT_CNT];
    localparam logic [FEAT_CNT-1:0] SIGN = W_SIGN[h*FEAT_CNT +: FEAT_CNT];

    logic signed [ACC_BITS-1:0] opt [FEAT_CNT];
    logic signed [ACC_BITS-1:0] sample;

    // weight applied per feature, fixed at elaboration
    for (genvar f = 0; f < FEAT_CNT; f++) begin : g_weight
      if (!MASK[f]) begin : g_zero
        assign opt[f] = '0;
      end else if (SIGN[f]) begin : g_plus
        assign opt[f] = feat_ext[f];
      end else begin : g_minus
        assign opt[f] = -feat_ext[f];
      end
    end

    assign sample = opt[cnt];

    ternary_accumulator #(
      .ACC_BITS (ACC_BITS)
    ) u_acc (
      .clk      (clk),
      .rst      (rst),
      .start    (acc_start),
      .sample   (sample),
      .enable   (acc_enable),
      .positive (hidden[h])
    );
  end

  a_hid_hold : assert property (
    @(posedge clk) disable iff (rst)
    (hid_valid && !hid_ready) |=> (hid_valid && $stable(hidden))
  ) else $error("hidden result dropped or changed while stalled");

  // counter in range, and parked at zero while idle
  a_cnt_range : assert property (
    @(posedge clk) disable iff (rst)
    (cnt <= CNT_LAST) && (busy || cnt == '0)
  ) else $error("feature counter out of range");

endmodule

/* hw/binary_output_layer.sv */
module binary_output_layer #(
  parameter int HIDDEN_CNT = tnn_pkg::HIDDEN_CNT,
  parameter int CLASS_CNT  = tnn_pkg::CLASS_CNT,
  parameter int SCORE_BITS = tnn_pkg::SCORE_BITS,
  parameter logic [CLASS_CNT*HIDDEN_CNT-1:0] W_MASK = tnn_pkg::L2_MASK,
  parameter logic [CLASS_CNT*HIDDEN_CNT-1:0] W_SIGN = tnn_pkg::L2_SIGN
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            hid_valid,
  input  logic [HIDDEN_CNT-1:0]           hidden,
  input  logic                            sc_ready,
  output logic                            hid_ready,
  output logic                            sc_valid,
  output logic [CLASS_CNT*SCORE_BITS-1:0] scores
);

  localparam logic signed [SCORE_BITS-1:0] STEP = 1;

  logic [CLASS_CNT*SCORE_BITS-1:0] score_next;
  logic                            load;

  // set bit counts +1, clear bit -1, then the weight sign flips it
  always_comb begin : score_calc
    logic signed [SCORE_BITS-1:0] acc;
    score_next = '0;
    for (int c = 0; c < CLASS_CNT; c++) begin
      acc = '0;
      for (int h = 0; h < HIDDEN_CNT; h++) begin
        if (W_MASK[c*HIDDEN_CNT + h]) begin
          if (hidden[h] == W_SIGN[c*HIDDEN_CNT + h]) begin
            acc = acc + STEP;
          end else begin
            acc = acc - STEP;
          end
        end
      end
      score_next[c*SCORE_BITS +: SCORE_BITS] = acc;
    end
  end

  // one-entry stage, free when empty or draining this cycle
  assign hid_ready = !sc_valid || sc_ready;
  assign load      = hid_valid && hid_ready;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sc_valid <= 1'b0;
    end else if (load) begin
      sc_valid <= 1'b1;
    end else if (sc_ready) begin
      sc_valid <= 1'b0;
    end
  end

  // score payload
  always_ff @(posedge clk) begin
    if (load) begin
      scores <= score_next;
    end
  end

  a_sc_hold : assert property (
    @(posedge clk) disable iff (rst)
    (sc_valid && !sc_ready) |=> (sc_valid && $stable(scores))
  ) else $error("class scores not held under stall");

endmodule

/* hw/class_argmax.sv */
module class_argmax #(
  parameter int CLASS_CNT  = tnn_pkg::CLASS_CNT,
  parameter int SCORE_BITS = tnn_pkg::SCORE_BITS,
  parameter int CLASS_BITS = tnn_pkg::CLASS_BITS
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            sc_valid,
  input  logic [CLASS_CNT*SCORE_BITS-1:0] scores,
  input  logic                            out_ready,
  output logic                            sc_ready,
  output logic                            out_valid,
  output logic [CLASS_BITS-1:0]           out_class,
  output logic signed [SCORE_BITS-1:0]    out_score
);

  logic [CLASS_BITS-1:0]        best_class;
  logic signed [SCORE_BITS-1:0] best_score;
  logic                         load;

  // strictly greater replaces, so a tie keeps the lower index
  always_comb begin : max_scan
    logic signed [SCORE_BITS-1:0] cand;
    best_class = '0;
    best_score = $signed(scores[SCORE_BITS-1:0]);
    for (int c = 1; c < CLASS_CNT; c++) begin
      cand = $signed(scores[c*SCORE_BITS +: SCORE_BITS]);
      if (cand > best_score) begin
        best_score = cand;
        best_class = CLASS_BITS'(c);
      end
    end
  end

  assign sc_ready = !out_valid || out_ready;
  assign load     = sc_valid && sc_ready;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // winner payload
  always_ff @(posedge clk) begin
    if (load) begin
      out_class <= best_class;
      out_score <= best_score;
    end
  end

  a_out_hold : assert property (
    @(posedge clk) disable iff (rst)
    (out_valid && !out_ready)
    |=> (out_valid && $stable(out_class) && $stable(out_score))
  ) else $error("result changed before out_ready");

endmodule

/* hw/tnn_classifier.sv */
module tnn_classifier #(
  parameter int FEAT_CNT   = tnn_pkg::FEAT_CNT,
  parameter int FEAT_BITS  = tnn_pkg::FEAT_BITS,
  parameter int HIDDEN_CNT = tnn_pkg::HIDDEN_CNT,
  parameter int CLASS_CNT  = tnn_pkg::CLASS_CNT,
  parameter logic [HIDDEN_CNT*FEAT_CNT-1:0]  L1_MASK = tnn_pkg::L1_MASK,
  parameter logic [HIDDEN_CNT*FEAT_CNT-1:0]  L1_SIGN = tnn_pkg::L1_SIGN,
  parameter logic [CLASS_CNT*HIDDEN_CNT-1:0] L2_MASK = tnn_pkg::L2_MASK,
  parameter logic [CLASS_CNT*HIDDEN_CNT-1:0] L2_SIGN = tnn_pkg::L2_SIGN,
  // derived widths
  localparam int ACC_BITS   = tnn_pkg::acc_width(FEAT_CNT, FEAT_BITS),
  localparam int SCORE_BITS = tnn_pkg::score_width(HIDDEN_CNT),
  localparam int CLASS_BITS = tnn_pkg::index_width(CLASS_CNT)
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          in_valid,
  input  logic [FEAT_CNT*FEAT_BITS-1:0] features,
  input  logic                          out_ready,
  output logic                          in_ready,
  output logic                          out_valid,
  output logic [CLASS_BITS-1:0]         out_class,
  output logic signed [SCORE_BITS-1:0]  out_score
);

  // first layer to output layer
  logic                            hid_valid;
  logic                            hid_ready;
  logic [HIDDEN_CNT-1:0]           hidden;

  // output layer to arg-max
  logic                            sc_valid;
  logic                            sc_ready;
  logic [CLASS_CNT*SCORE_BITS-1:0] scores;

  ternary_first_layer #(
    .FEAT_CNT   (FEAT_CNT),
    .FEAT_BITS  (FEAT_BITS),
    .HIDDEN_CNT (HIDDEN_CNT),
    .ACC_BITS   (ACC_BITS),
    .W_MASK     (L1_MASK),
    .W_SIGN     (L1_SIGN)
  ) u_first (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .features  (features),
    .hid_ready (hid_ready),
    .in_ready  (in_ready),
    .hid_valid (hid_valid),
    .hidden    (hidden)
  );

  binary_output_layer #(
    .HIDDEN_CNT (HIDDEN_CNT),
    .CLASS_CNT  (CLASS_CNT),
    .SCORE_BITS (SCORE_BITS),
    .W_MASK     (L2_MASK),
    .W_SIGN     (L2_SIGN)
  ) u_out (
    .clk       (clk),
    .rst       (rst),
    .hid_valid (hid_valid),
    .hidden    (hidden),
    .sc_ready  (sc_ready),
    .hid_ready (hid_ready),
    .sc_valid  (sc_valid),
    .scores    (scores)
  );

  class_argmax #(
    .CLASS_CNT  (CLASS_CNT),
    .SCORE_BITS (SCORE_BITS),
    .CLASS_BITS (CLASS_BITS)
  ) u_argmax (
    .clk       (clk),
    .rst       (rst),
    .sc_valid  (sc_valid),
    .scores    (scores),
    .out_ready (out_ready),
    .sc_ready  (sc_ready),
    .out_valid (out_valid),
    .out_class (out_class),
    .out_score (out_score)
  );

endmodule

/* tests/tnn_classifier_tb.sv */
module tnn_classifier_tb;

  localparam int FEAT_CNT    = tnn_pkg::FEAT_CNT;
  localparam int FEAT_BITS   = tnn_pkg::FEAT_BITS;
  localparam int HIDDEN_CNT  = tnn_pkg::HIDDEN_CNT;
  localparam int CLASS_CNT   = tnn_pkg::CLASS_CNT;
  localparam int SCORE_BITS  = tnn_pkg::SCORE_BITS;
  localparam int CLASS_BITS  = tnn_pkg::CLASS_BITS;
  localparam int FEAT_W      = FEAT_CNT * FEAT_BITS;
  localparam int CLK_PERIOD  = 100;
  localparam int DRIVE_DELAY = 10;
  localparam int LATENCY     = FEAT_CNT + 2;
  localparam logic [FEAT_BITS-1:0] FEAT_MAX = '1;

  localparam int STREAM_CNT   = 40;
  localparam int PRESSURE_CNT = 30;
  localparam int TIE_CNT      = 6;
  localparam int RESET_BATCH  = 6;
  localparam int VEC_TOTAL    = 3 + STREAM_CNT + PRESSURE_CNT + TIE_CNT + 2 * RESET_BATCH;
  localparam int MARGIN       = 400;

  logic                         clk;
  logic                         rst;
  logic                         in_valid;
  logic [FEAT_W-1:0]            features;
  logic                         out_ready;
  logic                         in_ready;
  logic                         out_valid;
  logic [CLASS_BITS-1:0]        out_class;
  logic signed [SCORE_BITS-1:0] out_score;

  // vectors waiting to be offered, and accepted ones waiting for results
  logic [FEAT_W-1:0] stim_q [$];
  logic [FEAT_W-1:0] exp_feat [$];
  int                exp_cycle [$];

  int seed;
  int cycle = 0;
  int err_count = 0;
  int check_count = 0;
  int out_count = 0;
  int test_count = 0;
  int fail_tests = 0;
  bit random_ready = 1'b0;
  bit stall_out = 1'b0;
  bit check_latency = 1'b0;
  bit check_spacing = 1'b0;
  bit have_last = 1'b0;
  int last_accept;
  bit hold_pending = 1'b0;
  int held_class;
  int held_score;

  tnn_classifier u_dut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .features  (features),
    .out_ready (out_ready),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_class (out_class),
    .out_score (out_score)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic report_mismatch(input string sig, input int got, input int expected);
    $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, sig, got, expected);
    err_count++;
  endtask

  task automatic report_failure(input string what);
    $display("ERROR at %0t: %s", $time, what);
    err_count++;
  endtask

  // two-layer ternary network straight from the weight tables
  function automatic void reference_classify(input logic [FEAT_W-1:0] vec, output int cls,
                                             output int score, output bit tie);
    int sum;
    int sc;
    int w;
    int hid [HIDDEN_CNT];
    for (int h = 0; h < HIDDEN_CNT; h++) begin
      sum = 0;
      for (int f = 0; f < FEAT_CNT; f++) begin
        if (tnn_pkg::L1_MASK[h*FEAT_CNT + f]) begin
          w = tnn_pkg::L1_SIGN[h*FEAT_CNT + f] ? 1 : -1;
          sum += w * int'(vec[f*FEAT_BITS +: FEAT_BITS]);
        end
      end
      // hidden bit as +1 / -1
      hid[h] = (sum > 0) ? 1 : -1;
    end
    cls = 0;
    score = -(HIDDEN_CNT + 1);
    tie = 1'b0;
    for (int c = 0; c < CLASS_CNT; c++) begin
      sc = 0;
      for (int h = 0; h < HIDDEN_CNT; h++) begin
        if (tnn_pkg::L2_MASK[c*HIDDEN_CNT + h]) begin
          w = tnn_pkg::L2_SIGN[c*HIDDEN_CNT + h] ? 1 : -1;
          sc += w * hid[h];
        end
      end
      if (sc > score) begin
        score = sc;
        cls = c;
        tie = 1'b0;
      end else if (sc == score) begin
        tie = 1'b1;
      end
    end
  endfunction

  function automatic logic [FEAT_W-1:0] random_vector();
    logic [FEAT_W-1:0] vec;
    for (int f = 0; f < FEAT_CNT; f++) begin
      vec[f*FEAT_BITS +: FEAT_BITS] = $random(seed);
    end
    return vec;
  endfunction

  // input side, offers the head of stim_q
  initial begin : driver
    in_valid = 1'b0;
    features = '0;
    forever begin
      @(posedge clk);
      if (!rst && in_valid && in_ready) begin
        exp_feat.push_back(features);
        exp_cycle.push_back(cycle);
        void'(stim_q.pop_front());
        if (check_spacing && have_last) begin
          assert ((cycle - last_accept) == FEAT_CNT)
            else report_mismatch("accept_interval", cycle - last_accept, FEAT_CNT);
        end
        last_accept = cycle;
        have_last = 1'b1;
      end
      #(DRIVE_DELAY);
      if (stim_q.size() > 0) begin
        in_valid = 1'b1;
        features = stim_q[0];
      end else begin
        in_valid = 1'b0;
      end
    end
  end

  initial begin : ready_gen
    out_ready = 1'b1;
    forever begin
      @(posedge clk);
      #(DRIVE_DELAY);
      if (stall_out) begin
        out_ready = 1'b0;
      end else if (random_ready) begin
        out_ready = $random(seed) & 1;
      end else begin
        out_ready = 1'b1;
      end
    end
  end

  // compares every output transfer with the reference
  always @(posedge clk) begin : monitor
    logic [FEAT_W-1:0] vec;
    int acc_at;
    int exp_cls;
    int exp_sc;
    int got_sc;
    bit tie;
    if (rst) begin
      hold_pending = 1'b0;
    end else begin
      got_sc = out_score;
      // stalled result must not move
      if (hold_pending) begin
        assert (out_valid === 1'b1)
          else report_failure("out_valid dropped before out_ready");
        assert (out_class === CLASS_BITS'(held_class))
          else report_mismatch("out_class (stalled)", out_class, held_class);
        assert (got_sc == held_score)
          else report_mismatch("out_score (stalled)", got_sc, held_score);
      end
      if (out_valid && out_ready) begin
        if (exp_feat.size() == 0) begin
          report_failure("result transferred with no vector outstanding");
        end else begin
          vec = exp_feat.pop_front();
          acc_at = exp_cycle.pop_front();
          reference_classify(vec, exp_cls, exp_sc, tie);
          check_count++;
          assert (out_class == exp_cls) else report_mismatch("out_class", out_class, exp_cls);
          assert (got_sc == exp_sc) else report_mismatch("out_score", got_sc, exp_sc);
          // out_valid rose on the edge before this one
          if (check_latency) begin
            assert ((cycle - acc_at - 1) == LATENCY)
              else report_mismatch("output latency", cycle - acc_at - 1, LATENCY);
          end
          out_count++;
        end
      end
      hold_pending = out_valid && !out_ready;
      held_class = out_class;
      held_score = got_sc;
    end
  end

  task automatic wait_drain();
    do begin
      @(negedge clk);
    end while (stim_q.size() != 0 || exp_feat.size() != 0);
  endtask

  task automatic finish_test(input string name, input int err_before);
    test_count++;
    if (err_count == err_before) begin
      $display("test %s: pass", name);
    end else begin
      fail_tests++;
      $display("test %s: FAIL, %0d errors", name, err_count - err_before);
    end
  endtask

  task automatic fixed_test();
    logic [FEAT_W-1:0] vec;
    int err_before;
    err_before = err_count;
    check_latency = 1'b1;
    for (int k = 0; k < 3; k++) begin
      for (int f = 0; f < FEAT_CNT; f++) begin
        case (k)
          0: vec[f*FEAT_BITS +: FEAT_BITS] = '0;
          1: vec[f*FEAT_BITS +: FEAT_BITS] = FEAT_MAX;
          default: vec[f*FEAT_BITS +: FEAT_BITS] = (f % 2 == 0) ? FEAT_MAX : '0;
        endcase
      end
      @(posedge clk);
      stim_q.push_back(vec);
      wait_drain();
    end
    check_latency = 1'b0;
    finish_test("fixed vectors", err_before);
  endtask

  task automatic stream_test();
    int err_before;
    err_before = err_count;
    @(posedge clk);
    have_last = 1'b0;
    check_spacing = 1'b1;
    for (int i = 0; i < STREAM_CNT; i++) begin
      stim_q.push_back(random_vector());
    end
    wait_drain();
    check_spacing = 1'b0;
    finish_test("back-to-back stream", err_before);
  endtask

  task automatic pressure_test();
    int err_before;
    err_before = err_count;
    @(posedge clk);
    for (int i = 0; i < PRESSURE_CNT; i++) begin
      stim_q.push_back(random_vector());
    end
    random_ready = 1'b1;
    wait_drain();
    random_ready = 1'b0;
    finish_test("random back-pressure", err_before);
  endtask

  task automatic tie_test();
    logic [FEAT_W-1:0] vec;
    int err_before;
    int cls;
    int sc;
    int found;
    bit tie;
    err_before = err_count;
    found = 0;
    @(posedge clk);
    // keep only vectors whose top score is shared
    for (int tries = 0; tries < 5000 && found < TIE_CNT; tries++) begin
      vec = random_vector();
      reference_classify(vec, cls, sc, tie);
      if (tie) begin
        stim_q.push_back(vec);
        found++;
      end
    end
    if (found < TIE_CNT) begin
      report_failure($sformatf("only %0d tie vectors found", found));
    end
    wait_drain();
    finish_test("tie handling", err_before);
  endtask

  task automatic reset_test();
    int err_before;
    int base;
    err_before = err_count;
    base = out_count;
    @(posedge clk);
    for (int i = 0; i < RESET_BATCH; i++) begin
      stim_q.push_back(random_vector());
    end
    while (out_count < base + 2) begin
      @(negedge clk);
    end
    // hold the output so a result is still waiting when reset hits
    stall_out = 1'b1;
    do begin
      @(negedge clk);
    end while (!(out_valid && !out_ready));
    if (exp_feat.size() == 0) begin
      report_failure("no vector in flight when reset was applied");
    end
    @(posedge clk);
    #(DRIVE_DELAY);
    rst = 1'b1;
    stim_q.delete();
    exp_feat.delete();
    exp_cycle.delete();
    #(DRIVE_DELAY);
    assert (out_valid === 1'b0) else report_failure("out_valid still high during reset");
    assert (in_ready === 1'b0) else report_failure("in_ready high during reset");
    repeat (8) @(posedge clk);
    #(DRIVE_DELAY);
    rst = 1'b0;
    stall_out = 1'b0;
    #(DRIVE_DELAY);
    assert (in_ready === 1'b1) else report_failure("in_ready not high after reset");
    @(posedge clk);
    for (int i = 0; i < RESET_BATCH; i++) begin
      stim_q.push_back(random_vector());
    end
    wait_drain();
    finish_test("reset mid-run", err_before);
  endtask

  initial begin : main
    seed = 15705;
    rst = 1'b1;
    repeat (8) @(posedge clk);
    #(DRIVE_DELAY);
    rst = 1'b0;
    fixed_test();
    stream_test();
    pressure_test();
    tie_test();
    reset_test();
    $display("tests %0d, failed %0d, results checked %0d, errors %0d",
             test_count, fail_tests, check_count, err_count);
    if (err_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // upper bound from the number of vectors, each needing a few cycles past the walk
  initial begin : watchdog
    #((VEC_TOTAL * (FEAT_CNT + 4) + MARGIN) * CLK_PERIOD);
    $display("watchdog expired, the run did not finish in time");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* sim.f */
hw/tnn_pkg.sv
hw/ternary_accumulator.sv
hw/ternary_first_layer.sv
hw/binary_output_layer.sv
hw/class_argmax.sv
hw/tnn_classifier.sv
tests/tnn_classifier_tb.sv
